/* src/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// Memory sizes and program image
	//////////////////////////////////////////////////////////////////////
	localparam int ImemWords = 1024;
	localparam int DmemWords = 1024;
	localparam int ImemAddrW = $clog2(ImemWords);
	localparam int DmemAddrW = $clog2(DmemWords);
	localparam logic [31:0] ResetPc = 32'h0000_3000;
	localparam string ProgramFile = "verif/program.hex";

	// Primary opcodes
	localparam logic [5:0] OpSpecial = 6'h00;
	localparam logic [5:0] OpJ       = 6'h02;
	localparam logic [5:0] OpJal     = 6'h03;
	localparam logic [5:0] OpBeq     = 6'h04;
	localparam logic [5:0] OpBne     = 6'h05;
	localparam logic [5:0] OpAddiu   = 6'h09;
	localparam logic [5:0] OpOri     = 6'h0d;
	localparam logic [5:0] OpLui     = 6'h0f;
	localparam logic [5:0] OpLw      = 6'h23;
	localparam logic [5:0] OpSw      = 6'h2b;

	// SPECIAL function codes
	localparam logic [5:0] FnJr   = 6'h08;
	localparam logic [5:0] FnAddu = 6'h21;
	localparam logic [5:0] FnSubu = 6'h23;
	localparam logic [5:0] FnAnd  = 6'h24;
	localparam logic [5:0] FnOr   = 6'h25;
	localparam logic [5:0] FnSlt  = 6'h2a;

	// ALU operations
	localparam logic [2:0] AluAdd = 3'd0;
	localparam logic [2:0] AluSub = 3'd1;
	localparam logic [2:0] AluAnd = 3'd2;
	localparam logic [2:0] AluOr  = 3'd3;
	localparam logic [2:0] AluSlt = 3'd4;
	localparam logic [2:0] AluLui = 3'd5;

	// Writeback source, destination select, branch and jump kinds
	localparam logic [1:0] WbAlu   = 2'd0;
	localparam logic [1:0] WbMem   = 2'd1;
	localparam logic [1:0] WbPc8   = 2'd2;
	localparam logic [1:0] DstRt   = 2'd0;
	localparam logic [1:0] DstRd   = 2'd1;
	localparam logic [1:0] DstRa   = 2'd2;
	localparam logic [1:0] BrNone  = 2'd0;
	localparam logic [1:0] BrBeq   = 2'd1;
	localparam logic [1:0] BrBne   = 2'd2;
	localparam logic [1:0] JmpNone = 2'd0;
	localparam logic [1:0] JmpImm  = 2'd1;
	localparam logic [1:0] JmpReg  = 2'd2;

	// Next-PC codes from decode
	localparam logic [1:0] NpcPlus4  = 2'd0;
	localparam logic [1:0] NpcBranch = 2'd1;
	localparam logic [1:0] NpcJump   = 2'd2;
	localparam logic [1:0] NpcReg    = 2'd3;

	// Operand not read at all, never stalls
	localparam logic [1:0] TuseNone = 2'd3;

	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rView;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm16;
		} iView;
	} instrU;

	typedef struct packed {
		logic [2:0] aluOp;
		logic       aluSrcImm;
		logic       extSigned;
		logic       regWrite;
		logic [1:0] wbSel;
		logic [1:0] dstSel;
		logic       memWrite;
		logic [1:0] brKind;
		logic [1:0] jmpKind;
		logic [1:0] tuseRs;
		logic [1:0] tuseRt;
		// Cycles until result, counted from decode
		logic [1:0] tnew;
	} ctrlT;

	typedef struct packed {
		logic [31:0] pc;
		instrU       instr;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [4:0]  dst;
		ctrlT        ctrl;
	} deRegT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluRes;
		logic [31:0] storeData;
		logic [4:0]  rtAddr;
		logic [4:0]  dst;
		ctrlT        ctrl;
	} emRegT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluRes;
		logic [31:0] loadData;
		logic [4:0]  dst;
		ctrlT        ctrl;
	} mwRegT;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  addr;
		logic [31:0] data;
	} retireT;

	typedef struct packed {
		logic [31:0] pc;
		logic [29:0] addr;
		logic [31:0] data;
	} storeT;

	typedef struct packed {
		logic [4:0]  addr;
		logic [31:0] data;
		logic        ready;
	} fwdT;

	// Youngest matching producer wins, a pending one leaves the old value
	function automatic logic [31:0] fwdPick(fwdT young, fwdT old, logic [4:0] src,
			logic [31:0] regVal);
		logic [31:0] val;
		val = regVal;
		if (src != 5'd0 && young.addr == src) begin
			if (young.ready)
				val = young.data;
		end else if (src != 5'd0 && old.addr == src && old.ready) begin
			val = old.data;
		end
		return val;
	endfunction

	// One stage further down the pipe
	function automatic logic [1:0] tnewStep(logic [1:0] t);
		return (t == 2'd0) ? 2'd0 : t - 2'd1;
	endfunction

endpackage

`default_nettype wire

/* src/fetchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchUnit import mipsPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic        stall,
	input  logic [1:0]  npcSel,
	input  logic [31:0] branchTarget,
	output logic [31:0] pc,
	output instrU       instr
);

	logic [31:0] imem [ImemWords];
	logic [31:0] pcOffset;
	logic [31:0] nextPc;

	initial begin
		$readmemh(ProgramFile, imem);
	end

	// ROM is indexed relative to the reset vector
	assign pcOffset = pc - ResetPc;
	assign instr = imem[pcOffset[ImemAddrW+1:2]];

	//////////////////////////////////////////////////////////////////////
	// Next PC
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		if (stall) begin
			nextPc = pc;
		end else if (npcSel == NpcPlus4) begin
			nextPc = pc + 32'd4;
		end else begin
			// Taken branch or jump, target built in decode
			nextPc = branchTarget;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= ResetPc;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

/* src/hazardUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
	input  logic [4:0] rsD,
	input  logic [4:0] rtD,
	input  logic [1:0] tuseRsD,
	input  logic [1:0] tuseRtD,
	input  logic [4:0] dstE,
	input  logic [4:0] dstM,
	input  logic [1:0] tnewE,
	input  logic [1:0] tnewM,
	input  logic       writeE,
	input  logic       writeM,
	output logic       stall
);

	logic rsStallE;
	logic rsStallM;
	logic rtStallE;
	logic rtStallM;

	// Source waits on a producer whose result comes later than it is needed
	function automatic logic pending(logic [4:0] src, logic [1:0] tuse, logic [4:0] dst,
			logic [1:0] tnew, logic wr);
		return wr && (dst != 5'd0) && (dst == src) && (tnew > tuse);
	endfunction

	assign rsStallE = pending(rsD, tuseRsD, dstE, tnewE, writeE);
	assign rsStallM = pending(rsD, tuseRsD, dstM, tnewM, writeM);
	assign rtStallE = pending(rtD, tuseRtD, dstE, tnewE, writeE);
	assign rtStallM = pending(rtD, tuseRtD, dstM, tnewM, writeM);

	// Holds fetch and decode, execute gets a bubble
	assign stall = rsStallE | rsStallM | rtStallE | rtStallM;

endmodule

`default_nettype wire

/* src/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage import mipsPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic        stall,
	input  logic [31:0] fetchPc,
	input  instrU       fetchInstr,
	input  fwdT         fwdE,
	input  fwdT         fwdM,
	input  fwdT         wbPort,
	output deRegT       deReg,
	output logic [1:0]  npcSel,
	output logic [31:0] branchTarget,
	output logic [4:0]  rsD,
	output logic [4:0]  rtD,
	output logic [1:0]  tuseRsD,
	output logic [1:0]  tuseRtD
);

	logic [31:0] pcD;
	instrU       instrD;
	ctrlT        ctrl;
	logic [31:0] regs [32];
	logic [31:0] rfRs;
	logic [31:0] rfRt;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [31:0] immExt;
	logic [31:0] branchOff;
	logic [31:0] pcPlus4;
	logic [4:0]  dst;
	logic        taken;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcD <= '0;
			instrD <= '0;
		end else if (!stall) begin
			pcD <= fetchPc;
			instrD <= fetchInstr;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control decode
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		ctrl = '0;
		ctrl.tuseRs = TuseNone;
		ctrl.tuseRt = TuseNone;
		case (instrD.rView.op)
			OpSpecial: begin
				case (instrD.rView.funct)
					FnAddu, FnSubu, FnAnd, FnOr, FnSlt: begin
						ctrl.regWrite = 1'b1;
						ctrl.dstSel = DstRd;
						ctrl.tuseRs = 2'd1;
						ctrl.tuseRt = 2'd1;
						ctrl.tnew = 2'd2;
					end
					FnJr: begin
						ctrl.jmpKind = JmpReg;
						ctrl.tuseRs = 2'd0;
					end
					default: ctrl = ctrl;
				endcase
				case (instrD.rView.funct)
					FnSubu:  ctrl.aluOp = AluSub;
					FnAnd:   ctrl.aluOp = AluAnd;
					FnOr:    ctrl.aluOp = AluOr;
					FnSlt:   ctrl.aluOp = AluSlt;
					default: ctrl.aluOp = AluAdd;
				endcase
			end
			OpOri, OpAddiu, OpLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.tnew = 2'd2;
				ctrl.extSigned = (instrD.iView.op == OpAddiu);
				ctrl.tuseRs = (instrD.iView.op == OpLui) ? TuseNone : 2'd1;
				ctrl.aluOp = (instrD.iView.op == OpOri) ? AluOr :
					(instrD.iView.op == OpLui) ? AluLui : AluAdd;
			end
			OpLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.extSigned = 1'b1;
				ctrl.wbSel = WbMem;
				ctrl.tuseRs = 2'd1;
				ctrl.tnew = 2'd3;
			end
			OpSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.extSigned = 1'b1;
				ctrl.tuseRs = 2'd1;
				// Store data only needed in memory stage
				ctrl.tuseRt = 2'd2;
			end
			OpBeq, OpBne: begin
				ctrl.brKind = (instrD.iView.op == OpBeq) ? BrBeq : BrBne;
				ctrl.tuseRs = 2'd0;
				ctrl.tuseRt = 2'd0;
			end
			OpJ: ctrl.jmpKind = JmpImm;
			OpJal: begin
				ctrl.jmpKind = JmpImm;
				ctrl.regWrite = 1'b1;
				ctrl.dstSel = DstRa;
				ctrl.wbSel = WbPc8;
				ctrl.tnew = 2'd1;
			end
			default: ctrl = '0;
		endcase
	end

	assign rsD = instrD.rView.rs;
	assign rtD = instrD.rView.rt;
	assign tuseRsD = ctrl.tuseRs;
	assign tuseRtD = ctrl.tuseRt;

	// Register file, writeback data bypassed into same-cycle reads
	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (wbPort.addr != 5'd0)
			regs[wbPort.addr] <= wbPort.data;
	end

	assign rfRs = (rsD == 5'd0) ? '0 : (wbPort.addr == rsD) ? wbPort.data : regs[rsD];
	assign rfRt = (rtD == 5'd0) ? '0 : (wbPort.addr == rtD) ? wbPort.data : regs[rtD];
	assign rsVal = fwdPick(fwdE, fwdM, rsD, rfRs);
	assign rtVal = fwdPick(fwdE, fwdM, rtD, rfRt);

	assign immExt = ctrl.extSigned ? {{16{instrD.iView.imm16[15]}}, instrD.iView.imm16} :
		{16'h0000, instrD.iView.imm16};
	assign branchOff = {{14{instrD.iView.imm16[15]}}, instrD.iView.imm16, 2'b00};
	assign pcPlus4 = pcD + 32'd4;

	//////////////////////////////////////////////////////////////////////
	// Branch resolve and target
	//////////////////////////////////////////////////////////////////////
	assign taken = ((ctrl.brKind == BrBeq) && (rsVal == rtVal)) ||
		((ctrl.brKind == BrBne) && (rsVal != rtVal));

	always_comb begin
		npcSel = NpcPlus4;
		branchTarget = pcPlus4 + branchOff;
		if (ctrl.jmpKind == JmpReg) begin
			npcSel = NpcReg;
			branchTarget = rsVal;
		end else if (ctrl.jmpKind == JmpImm) begin
			npcSel = NpcJump;
			branchTarget = {pcPlus4[31:28], instrD.iView.rs, instrD.iView.rt,
				instrD.iView.imm16, 2'b00};
		end else if (taken) begin
			npcSel = NpcBranch;
		end
	end

	// Non-writing instructions carry register 0 as destination
	always_comb begin
		case (ctrl.dstSel)
			DstRd:   dst = instrD.rView.rd;
			DstRa:   dst = 5'd31;
			default: dst = instrD.rView.rt;
		endcase
		if (!ctrl.regWrite)
			dst = 5'd0;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			deReg <= '0;
		end else if (stall) begin
			deReg <= '0;
		end else begin
			deReg.pc <= pcD;
			deReg.instr <= instrD;
			deReg.rsVal <= rsVal;
			deReg.rtVal <= rtVal;
			deReg.imm <= immExt;
			deReg.dst <= dst;
			deReg.ctrl <= ctrl;
		end
	end

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage import mipsPkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  deRegT      deReg,
	input  fwdT        fwdM,
	input  fwdT        fwdW,
	output emRegT      emReg,
	output fwdT        fwdE,
	output logic [4:0] dstE,
	output logic [1:0] tnewE,
	output logic       writeE
);

	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] rtFwd;
	logic [31:0] aluOut;
	logic [31:0] result;

	// Operands captured in decode may still be stale
	assign srcA = fwdPick(fwdM, fwdW, deReg.instr.rView.rs, deReg.rsVal);
	assign rtFwd = fwdPick(fwdM, fwdW, deReg.instr.rView.rt, deReg.rtVal);
	assign srcB = deReg.ctrl.aluSrcImm ? deReg.imm : rtFwd;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (deReg.ctrl.aluOp)
			AluSub:  aluOut = srcA - srcB;
			AluAnd:  aluOut = srcA & srcB;
			AluOr:   aluOut = srcA | srcB;
			AluSlt:  aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
			AluLui:  aluOut = {srcB[15:0], 16'h0000};
			default: aluOut = srcA + srcB;
		endcase
	end

	// Link address for jal
	assign result = (deReg.ctrl.wbSel == WbPc8) ? deReg.pc + 32'd8 : aluOut;

	assign tnewE = tnewStep(deReg.ctrl.tnew);
	assign dstE = deReg.dst;
	assign writeE = deReg.ctrl.regWrite;

	assign fwdE.addr = writeE ? deReg.dst : 5'd0;
	assign fwdE.data = result;
	assign fwdE.ready = (tnewE == 2'd0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			emReg <= '0;
		end else begin
			emReg.pc <= deReg.pc;
			emReg.aluRes <= result;
			emReg.storeData <= rtFwd;
			emReg.rtAddr <= deReg.instr.rView.rt;
			emReg.dst <= deReg.dst;
			emReg.ctrl <= deReg.ctrl;
			emReg.ctrl.tnew <= tnewE;
		end
	end

endmodule

`default_nettype wire

/* src/memWbStage.sv */
`timescale 1ns/100ps
`default_nettype none

module memWbStage import mipsPkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  emRegT      emReg,
	output fwdT        fwdM,
	output fwdT        wbPort,
	output logic [4:0] dstM,
	output logic [1:0] tnewM,
	output logic       writeM,
	output logic       retireValid,
	output retireT     retireInfo,
	output logic       storeValid,
	output storeT      storeInfo
);

	logic [31:0] dmem [DmemWords];
	logic [DmemAddrW-1:0] wordIdx;
	logic [31:0] storeData;
	logic [31:0] loadData;
	logic [31:0] wbData;
	mwRegT mwReg;

	assign tnewM = tnewStep(emReg.ctrl.tnew);
	assign dstM = emReg.dst;
	assign writeM = emReg.ctrl.regWrite;

	// Loads are still pending here, everything else is ready
	assign fwdM.addr = writeM ? emReg.dst : 5'd0;
	assign fwdM.data = emReg.aluRes;
	assign fwdM.ready = (tnewM == 2'd0);

	//////////////////////////////////////////////////////////////////////
	// Data memory
	//////////////////////////////////////////////////////////////////////
	assign wordIdx = emReg.aluRes[DmemAddrW+1:2];

	// Value written back this cycle overrides stale store data
	assign storeData = (wbPort.addr != 5'd0 && wbPort.addr == emReg.rtAddr) ?
		wbPort.data : emReg.storeData;

	initial begin
		for (int i = 0; i < DmemWords; i++)
			dmem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (emReg.ctrl.memWrite)
			dmem[wordIdx] <= storeData;
	end

	assign loadData = dmem[wordIdx];

	assign storeValid = emReg.ctrl.memWrite;
	assign storeInfo.pc = emReg.pc;
	assign storeInfo.addr = emReg.aluRes[31:2];
	assign storeInfo.data = storeData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mwReg <= '0;
		end else begin
			mwReg.pc <= emReg.pc;
			mwReg.aluRes <= emReg.aluRes;
			mwReg.loadData <= loadData;
			mwReg.dst <= emReg.dst;
			mwReg.ctrl <= emReg.ctrl;
		end
	end

	// Writeback select
	assign wbData = (mwReg.ctrl.wbSel == WbMem) ? mwReg.loadData : mwReg.aluRes;

	assign wbPort.addr = mwReg.ctrl.regWrite ? mwReg.dst : 5'd0;
	assign wbPort.data = wbData;
	assign wbPort.ready = 1'b1;

	// One strobe per real register write
	assign retireValid = mwReg.ctrl.regWrite && (mwReg.dst != 5'd0);
	assign retireInfo.pc = mwReg.pc;
	assign retireInfo.addr = mwReg.dst;
	assign retireInfo.data = wbData;

endmodule

`default_nettype wire

/* src/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore import mipsPkg::*; (
	input  logic   clk,
	input  logic   rstN,
	output logic   retireValid,
	output retireT retireInfo,
	output logic   storeValid,
	output storeT  storeInfo
);

	logic [31:0] pc;
	instrU       instr;
	logic        stall;
	logic [1:0]  npcSel;
	logic [31:0] branchTarget;
	logic [4:0]  rsD;
	logic [4:0]  rtD;
	logic [1:0]  tuseRsD;
	logic [1:0]  tuseRtD;
	deRegT       deReg;
	emRegT       emReg;
	fwdT         fwdE;
	fwdT         fwdM;
	fwdT         wbPort;
	logic [4:0]  dstE;
	logic [4:0]  dstM;
	logic [1:0]  tnewE;
	logic [1:0]  tnewM;
	logic        writeE;
	logic        writeM;

	//////////////////////////////////////////////////////////////////////
	// Fetch side
	//////////////////////////////////////////////////////////////////////
	fetchUnit fetch_i (
		.clk          (clk),
		.rstN         (rstN),
		.stall        (stall),
		.npcSel       (npcSel),
		.branchTarget (branchTarget),
		.pc           (pc),
		.instr        (instr)
	);

	// Decode, execute and hazard control
	decodeStage decode_i (
		.clk          (clk),
		.rstN         (rstN),
		.stall        (stall),
		.fetchPc      (pc),
		.fetchInstr   (instr),
		.fwdE         (fwdE),
		.fwdM         (fwdM),
		.wbPort       (wbPort),
		.deReg        (deReg),
		.npcSel       (npcSel),
		.branchTarget (branchTarget),
		.rsD          (rsD),
		.rtD          (rtD),
		.tuseRsD      (tuseRsD),
		.tuseRtD      (tuseRtD)
	);

	executeStage execute_i (
		.clk    (clk),
		.rstN   (rstN),
		.deReg  (deReg),
		.fwdM   (fwdM),
		.fwdW   (wbPort),
		.emReg  (emReg),
		.fwdE   (fwdE),
		.dstE   (dstE),
		.tnewE  (tnewE),
		.writeE (writeE)
	);

	hazardUnit hazard_i (
		.rsD     (rsD),
		.rtD     (rtD),
		.tuseRsD (tuseRsD),
		.tuseRtD (tuseRtD),
		.dstE    (dstE),
		.dstM    (dstM),
		.tnewE   (tnewE),
		.tnewM   (tnewM),
		.writeE  (writeE),
		.writeM  (writeM),
		.stall   (stall)
	);

	// Memory and writeback, both output strobes
	memWbStage memWb_i (
		.clk         (clk),
		.rstN        (rstN),
		.emReg       (emReg),
		.fwdM        (fwdM),
		.wbPort      (wbPort),
		.dstM        (dstM),
		.tnewM       (tnewM),
		.writeM      (writeM),
		.retireValid (retireValid),
		.retireInfo  (retireInfo),
		.storeValid  (storeValid),
		.storeInfo   (storeInfo)
	);

endmodule

`default_nettype wire

/* verif/mipsCore_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore_checker import mipsPkg::*; (
	input logic   clk,
	input logic   rstN,
	input logic   retireValid,
	input retireT retireInfo,
	input logic   storeValid,
	input storeT  storeInfo
);

	// Architectural state of the reference model
	logic [31:0] mImem [ImemWords];
	logic [31:0] mDmem [DmemWords];
	logic [31:0] mRegs [32];
	logic [31:0] mPc;
	logic [31:0] mNpc;

	// Model events not yet matched against the DUT
	retireT retireQ [$];
	storeT  storeQ [$];
	retireT headRetire;
	storeT  headStore;
	logic   headRetireOk;
	logic   headStoreOk;

	// Next expected events as the assertions sample them
	retireT     expRetire;
	storeT      expStore;
	logic       retireKnown;
	logic       storeKnown;
	logic [2:0] cycleCnt;
	int         errCount = 0;
	int         retireCnt;
	int         storeCnt;

	//////////////////////////////////////////////////////////////////////
	// Sequential instruction-set model
	//////////////////////////////////////////////////////////////////////
	task resetModel();
		$readmemh(ProgramFile, mImem);
		for (int i = 0; i < DmemWords; i++)
			mDmem[i] = '0;
		for (int i = 0; i < 32; i++)
			mRegs[i] = '0;
		mPc = ResetPc;
		mNpc = ResetPc + 32'd4;
		retireQ.delete();
		storeQ.delete();
	endtask

	// Executes one instruction while mNpc holds its delay slot
	task stepModel();
		logic [31:0] ins;
		logic [31:0] off;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immS;
		logic [31:0] ea;
		logic [31:0] pcPlus4;
		logic [31:0] res;
		logic [31:0] npcNext;
		logic [4:0]  wAddr;
		logic        wEn;
		retireT      rEv;
		storeT       sEv;
		off = mPc - ResetPc;
		ins = mImem[off[ImemAddrW+1:2]];
		a = mRegs[ins[25:21]];
		b = mRegs[ins[20:16]];
		immS = {{16{ins[15]}}, ins[15:0]};
		ea = a + immS;
		pcPlus4 = mPc + 32'd4;
		npcNext = mNpc + 32'd4;
		wAddr = ins[20:16];
		wEn = 1'b1;
		res = '0;
		case (ins[31:26])
			OpSpecial: begin
				wAddr = ins[15:11];
				case (ins[5:0])
					FnAddu:  res = a + b;
					FnSubu:  res = a - b;
					FnAnd:   res = a & b;
					FnOr:    res = a | b;
					FnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FnJr: begin
						wEn = 1'b0;
						npcNext = a;
					end
					default: wEn = 1'b0;
				endcase
			end
			OpOri:   res = a | {16'h0000, ins[15:0]};
			OpAddiu: res = ea;
			OpLui:   res = {ins[15:0], 16'h0000};
			OpLw:    res = mDmem[ea[DmemAddrW+1:2]];
			OpSw: begin
				wEn = 1'b0;
				mDmem[ea[DmemAddrW+1:2]] = b;
				sEv.pc = mPc;
				sEv.addr = ea[31:2];
				sEv.data = b;
				storeQ.push_back(sEv);
			end
			OpBeq, OpBne: begin
				wEn = 1'b0;
				// Taken when equality matches the branch kind
				if ((a == b) == (ins[31:26] == OpBeq))
					npcNext = pcPlus4 + {immS[29:0], 2'b00};
			end
			OpJ, OpJal: begin
				wEn = (ins[31:26] == OpJal);
				wAddr = 5'd31;
				res = mPc + 32'd8;
				npcNext = {pcPlus4[31:28], ins[25:0], 2'b00};
			end
			default: wEn = 1'b0;
		endcase
		if (wEn && wAddr != 5'd0) begin
			mRegs[wAddr] = res;
			rEv.pc = mPc;
			rEv.addr = wAddr;
			rEv.data = res;
			retireQ.push_back(rEv);
		end
		mPc = mNpc;
		mNpc = npcNext;
	endtask

	// Run the model until the next register write is known
	task takeRetire();
		int guard;
		guard = 0;
		while (retireQ.size() == 0 && guard < 1000) begin
			stepModel();
			guard++;
		end
		headRetireOk = (retireQ.size() != 0);
		if (headRetireOk)
			headRetire = retireQ.pop_front();
	endtask

	task takeStore();
		int guard;
		guard = 0;
		while (storeQ.size() == 0 && guard < 1000) begin
			stepModel();
			guard++;
		end
		headStoreOk = (storeQ.size() != 0);
		if (headStoreOk)
			headStore = storeQ.pop_front();
	endtask

	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resetModel();
			takeRetire();
			takeStore();
			retireCnt <= 0;
			storeCnt <= 0;
			cycleCnt <= '0;
		end else begin
			if (retireValid) begin
				retireCnt <= retireCnt + 1;
				takeRetire();
			end
			if (storeValid) begin
				storeCnt <= storeCnt + 1;
				takeStore();
			end
			if (cycleCnt != 3'd4)
				cycleCnt <= cycleCnt + 3'd1;
		end
		expRetire <= headRetire;
		retireKnown <= headRetireOk;
		expStore <= headStore;
		storeKnown <= headStoreOk;
	end

	//////////////////////////////////////////////////////////////////////
	// Assertions on the two strobes
	//////////////////////////////////////////////////////////////////////
	retireExpected: assert property (@(posedge clk) disable iff (!rstN)
		retireValid |-> retireKnown)
	else begin
		errCount++;
		$error("Retire strobe at %0t with no register write left in the model", $time);
	end

	retireMatch: assert property (@(posedge clk) disable iff (!rstN)
		retireValid |-> (retireInfo == expRetire))
	else begin
		errCount++;
		$error("Error at %0t: retireInfo is %h, expected %h", $time,
			$sampled(retireInfo), $sampled(expRetire));
	end

	storeExpected: assert property (@(posedge clk) disable iff (!rstN)
		storeValid |-> storeKnown)
	else begin
		errCount++;
		$error("Store strobe at %0t with no store left in the model", $time);
	end

	storeMatch: assert property (@(posedge clk) disable iff (!rstN)
		storeValid |-> (storeInfo == expStore))
	else begin
		errCount++;
		$error("Error at %0t: storeInfo is %h, expected %h", $time,
			$sampled(storeInfo), $sampled(expStore));
	end

	// Pipeline is still filling
	quietAfterReset: assert property (@(posedge clk) disable iff (!rstN)
		(cycleCnt < 3'd4) |-> (!retireValid && !storeValid))
	else begin
		errCount++;
		$error("Strobe raised at %0t before the first instruction could retire", $time);
	end

endmodule

`default_nettype wire

/* verif/mipsTb.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsTb import mipsPkg::*; ();

	logic        clk;
	logic        rstN;
	logic        retireValid;
	retireT      retireInfo;
	logic        storeValid;
	storeT       storeInfo;
	logic [31:0] loopPc;
	logic        loopSeen;
	int          otherErrors;
	int          totalErrors;

	mipsCore dut_i (
		.clk         (clk),
		.rstN        (rstN),
		.retireValid (retireValid),
		.retireInfo  (retireInfo),
		.storeValid  (storeValid),
		.storeInfo   (storeInfo)
	);

	bind mipsCore mipsCore_checker checker_i (
		.clk         (clk),
		.rstN        (rstN),
		.retireValid (retireValid),
		.retireInfo  (retireInfo),
		.storeValid  (storeValid),
		.storeInfo   (storeInfo)
	);

	always #5 clk = ~clk;

	// Sampled on the falling edge, where the strobes are stable
	task automatic waitForRetireAt(input logic [31:0] pcWanted, input int limit,
			output logic found);
		int cnt;
		found = 1'b0;
		cnt = 0;
		while (!found && cnt < limit) begin
			@(negedge clk);
			if (retireValid && retireInfo.pc == pcWanted)
				found = 1'b1;
			cnt++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		otherErrors = 0;
		// Closing self-loop jal in the program image
		loopPc = ResetPc + 32'h0000_0084;

		repeat (5) @(negedge clk);
		rstN = 1'b1;

		waitForRetireAt(loopPc, 3000, loopSeen);
		if (!loopSeen) begin
			otherErrors++;
			$display("Timed out after 3000 cycles waiting for the closing loop to retire");
		end
		if (dut_i.checker_i.storeKnown) begin
			otherErrors++;
			$display("A store predicted by the model never appeared on the store strobe");
		end

		totalErrors = dut_i.checker_i.errCount + otherErrors;
		$display("Retires %0d, stores %0d, assertion errors %0d, other errors %0d",
			dut_i.checker_i.retireCnt, dut_i.checker_i.storeCnt,
			dut_i.checker_i.errCount, otherErrors);
		if (totalErrors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/program.hex */
// Instruction ROM image, one 32-bit word per line, first word at 0x3000
// Column 1 is the hex word, the comment gives its address and assembly
3c011234 // 3000 lui   $1, 0x1234
34215678 // 3004 ori   $1, $1, 0x5678
2402fffd // 3008 addiu $2, $0, -3
00221821 // 300c addu  $3, $1, $2
00612023 // 3010 subu  $4, $3, $1
0041282a // 3014 slt   $5, $2, $1
00a13024 // 3018 and   $6, $5, $1
00c33825 // 301c or    $7, $6, $3
ac070000 // 3020 sw    $7, 0($0)
8c080000 // 3024 lw    $8, 0($0)
01084821 // 3028 addu  $9, $8, $8
ac090004 // 302c sw    $9, 4($0)
8c0a0004 // 3030 lw    $10, 4($0)
11490002 // 3034 beq   $10, $9, 0x3040
240b0001 // 3038 addiu $11, $0, 1
240c0002 // 303c addiu $12, $0, 2
00220021 // 3040 addu  $0, $1, $2
15600003 // 3044 bne   $11, $0, 0x3054
340d00ff // 3048 ori   $13, $0, 0x00ff
240c0007 // 304c addiu $12, $0, 7
240c0008 // 3050 addiu $12, $0, 8
11a00006 // 3054 beq   $13, $0, 0x3070
25ae0001 // 3058 addiu $14, $13, 1
0c000c1e // 305c jal   0x3078
03e07821 // 3060 addu  $15, $31, $0
ac0e0008 // 3064 sw    $14, 8($0)
8c130008 // 3068 lw    $19, 8($0)
ac13000c // 306c sw    $19, 12($0)
08000c21 // 3070 j     0x3084
26700005 // 3074 addiu $16, $19, 5
27f10004 // 3078 addiu $17, $31, 4
03e00008 // 307c jr    $31
022e9025 // 3080 or    $18, $17, $14
0c000c21 // 3084 jal   0x3084
00000000 // 3088 nop

/* sim.f */
src/mipsPkg.sv
src/fetchUnit.sv
src/hazardUnit.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/mipsCore.sv
verif/mipsCore_checker.sv
verif/mipsTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal --top-module mipsTb \
	-f sim.f -o mipsSim \
	&& ./obj_dir/mipsSim +verilator+error+limit+1000 | tee sim.log \
	|| echo "Build or simulation did not complete"
grep -q "^NO ERRORS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
